// File: common/vlane_defines.svh
/* lane multiply sizes: data width, extended factor and product widths,
   request to response latency */
`ifndef VLANE_DEFINES_SVH
`define VLANE_DEFINES_SVH

// operand and result width
`define VLANE_XLEN 32
// one guard bit so unsigned 32-bit operands stay positive
`define VLANE_FACTOR_W (`VLANE_XLEN + 1)
`define VLANE_PROD_W (2 * `VLANE_FACTOR_W)
// prep, multiply, result stages
`define VLANE_MUL_LAT 3

`endif

// File: common/vlane_pkg.sv
/* lane multiply types: element width and opcode enums,
   request, control sideband and response structs */
`default_nettype none
`include "vlane_defines.svh"

package vlane_pkg;

  // element width
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_t;

  // multiply opcodes, each one fixes its own sign handling
  typedef enum logic [2:0] {
    OP_MUL   = 3'd0,  // low sew bits of vs1*vs2
    OP_MULH  = 3'd1,  // high sew bits of vs1*vs2
    OP_WMUL  = 3'd2,  // low 2*sew bits of vs1*vs2
    OP_MACC  = 3'd3,  // vd + vs1*vs2
    OP_NMSAC = 3'd4,  // vd - vs1*vs2
    OP_MADD  = 3'd5,  // vs1*vd + vs2
    OP_NMSUB = 3'd6   // vs2 - vs1*vd
  } mul_op_t;

  // one element operation into the lane
  typedef struct packed {
    logic [`VLANE_XLEN-1:0] vs1;
    logic [`VLANE_XLEN-1:0] vs2;
    logic [`VLANE_XLEN-1:0] vd;
    sew_t                   sew;
    mul_op_t                op;
    // bit 0 vs1, bit 1 multiplicand
    logic [1:0]             signed_ops;
  } mul_req_t;

  // control that rides along with the factors and product
  typedef struct packed {
    sew_t                   sew;
    mul_op_t                op;
    // already routed and cut to sew bits
    logic [`VLANE_XLEN-1:0] addend;
  } mul_ctrl_t;

  // element result
  typedef struct packed {
    logic [`VLANE_XLEN-1:0] result;
  } mul_resp_t;

endpackage

`default_nettype wire

// File: vmul/vmul_operand_prep.sv
/* operand prep stage: per-sew extension of both factors, fused-form
   routing of multiplicand and addend, first pipeline register */
`timescale 1ns/1ns
`default_nettype none
`include "vlane_defines.svh"

module vmul_operand_prep (
  input  logic                      CLK,
  input  logic                      nRST,
  input  logic                      flush,
  input  logic                      in_valid,
  input  vlane_pkg::mul_req_t       in_req,
  output logic                      prep_valid,
  output logic [`VLANE_FACTOR_W-1:0] factor_a,
  output logic [`VLANE_FACTOR_W-1:0] factor_b,
  output vlane_pkg::mul_ctrl_t      prep_ctrl
);

  logic [`VLANE_XLEN-1:0]     mcand;
  logic [`VLANE_XLEN-1:0]     addend_raw;
  logic                       swap_vd;
  logic [`VLANE_FACTOR_W-1:0] ext_a;
  logic [`VLANE_FACTOR_W-1:0] ext_b;
  vlane_pkg::mul_ctrl_t       ctrl_d;

  // low sew bits, sign or zero filled up to 33 bits
  function automatic logic [`VLANE_FACTOR_W-1:0] extend(
    input logic [`VLANE_XLEN-1:0] v,
    input vlane_pkg::sew_t        sew,
    input logic                   sgn
  );
    logic fill;
    case (sew)
      vlane_pkg::SEW8: begin
        fill = sgn & v[7];
        extend = {{25{fill}}, v[7:0]};
      end
      vlane_pkg::SEW16: begin
        fill = sgn & v[15];
        extend = {{17{fill}}, v[15:0]};
      end
      default: begin
        fill = sgn & v[31];
        extend = {fill, v};
      end
    endcase
  endfunction

  // low sew bits only, nothing above
  function automatic logic [`VLANE_XLEN-1:0] cut_sew(
    input logic [`VLANE_XLEN-1:0] v,
    input vlane_pkg::sew_t        sew
  );
    case (sew)
      vlane_pkg::SEW8:  cut_sew = {24'd0, v[7:0]};
      vlane_pkg::SEW16: cut_sew = {16'd0, v[15:0]};
      default:          cut_sew = v;
    endcase
  endfunction

  // madd and nmsub multiply by vd and add vs2
  assign swap_vd = (in_req.op == vlane_pkg::OP_MADD) | (in_req.op == vlane_pkg::OP_NMSUB);
  assign mcand      = swap_vd ? in_req.vd  : in_req.vs2;
  assign addend_raw = swap_vd ? in_req.vs2 : in_req.vd;

  assign ext_a = extend(in_req.vs1, in_req.sew, in_req.signed_ops[0]);
  assign ext_b = extend(mcand, in_req.sew, in_req.signed_ops[1]);

  assign ctrl_d.sew    = in_req.sew;
  assign ctrl_d.op     = in_req.op;
  assign ctrl_d.addend = cut_sew(addend_raw, in_req.sew);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      prep_valid <= 1'b0;
      factor_a   <= '0;
      factor_b   <= '0;
      prep_ctrl  <= '0;
    end else begin
      // flush also drops a request on the same edge
      prep_valid <= in_valid & ~flush;
      if (in_valid) begin
        factor_a  <= ext_a;
        factor_b  <= ext_b;
        prep_ctrl <= ctrl_d;
      end
    end
  end

endmodule

`default_nettype wire

// File: vmul/vmul_multiplier.sv
/* multiply stage: signed 33x33 product register with the control
   sideband and valid carried alongside */
`timescale 1ns/1ns
`default_nettype none
`include "vlane_defines.svh"

module vmul_multiplier (
  input  logic                       CLK,
  input  logic                       nRST,
  input  logic                       flush,
  input  logic                       prep_valid,
  input  logic [`VLANE_FACTOR_W-1:0] factor_a,
  input  logic [`VLANE_FACTOR_W-1:0] factor_b,
  input  vlane_pkg::mul_ctrl_t       prep_ctrl,
  output logic                       prod_valid,
  output logic [`VLANE_PROD_W-1:0]   product,
  output vlane_pkg::mul_ctrl_t       prod_ctrl
);

  logic signed [`VLANE_FACTOR_W-1:0] sa;
  logic signed [`VLANE_FACTOR_W-1:0] sb;
  logic signed [`VLANE_PROD_W-1:0]   prod_d;

  // factors are already extended, so always a signed multiply
  assign sa = $signed(factor_a);
  assign sb = $signed(factor_b);

  // full 66-bit product, no overflow possible
  assign prod_d = sa * sb;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      prod_valid <= 1'b0;
    end else if (flush) begin
      prod_valid <= 1'b0;
    end else begin
      prod_valid <= prep_valid;
    end
  end

  // product and sideband advance together
  // so each op in flight keeps its own control
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      product   <= '0;
      prod_ctrl <= '0;
    end else if (prep_valid) begin
      product   <= prod_d;
      prod_ctrl <= prep_ctrl;
    end
  end

endmodule

`default_nettype wire

// File: vmul/vmul_result_unit.sv
/* result stage: product slice select, negation, fused add,
   sew truncation and output register */
`timescale 1ns/1ns
`default_nettype none
`include "vlane_defines.svh"

module vmul_result_unit (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     flush,
  input  logic                     prod_valid,
  input  logic [`VLANE_PROD_W-1:0] product,
  input  vlane_pkg::mul_ctrl_t     prod_ctrl,
  output logic                     out_valid,
  output vlane_pkg::mul_resp_t     out_resp
);

  logic [`VLANE_XLEN-1:0] lo_slice;
  logic [`VLANE_XLEN-1:0] hi_slice;
  logic [`VLANE_XLEN-1:0] wide_slice;
  logic [`VLANE_XLEN-1:0] prod_term;
  logic [`VLANE_XLEN-1:0] fused_sum;
  logic                   negate;
  logic                   fused;
  logic [`VLANE_XLEN-1:0] result_d;

  // zero above sew
  function automatic logic [`VLANE_XLEN-1:0] cut_sew(
    input logic [`VLANE_XLEN-1:0] v,
    input vlane_pkg::sew_t        sew
  );
    case (sew)
      vlane_pkg::SEW8:  cut_sew = {24'd0, v[7:0]};
      vlane_pkg::SEW16: cut_sew = {16'd0, v[15:0]};
      default:          cut_sew = v;
    endcase
  endfunction

  // low word covers the low sew bits at every width
  assign lo_slice = product[`VLANE_XLEN-1:0];

  // high half of the 2*sew product
  always_comb begin
    case (prod_ctrl.sew)
      vlane_pkg::SEW8:  hi_slice = {24'd0, product[15:8]};
      vlane_pkg::SEW16: hi_slice = {16'd0, product[31:16]};
      default:          hi_slice = product[63:32];
    endcase
  end

  // widened result, at sew32 only the low word fits
  always_comb begin
    case (prod_ctrl.sew)
      vlane_pkg::SEW8: wide_slice = {16'd0, product[15:0]};
      default:         wide_slice = product[31:0];
    endcase
  end

  // nmsac and nmsub subtract the product from the addend
  assign negate = (prod_ctrl.op == vlane_pkg::OP_NMSAC) | (prod_ctrl.op == vlane_pkg::OP_NMSUB);
  assign fused  = negate | (prod_ctrl.op == vlane_pkg::OP_MACC) |
                  (prod_ctrl.op == vlane_pkg::OP_MADD);

  assign prod_term = negate ? (`VLANE_XLEN'(0) - lo_slice) : lo_slice;
  // wraps mod 2^32, truncation below takes it to mod 2^sew
  assign fused_sum = prod_term + prod_ctrl.addend;

  always_comb begin
    if (fused) begin
      result_d = cut_sew(fused_sum, prod_ctrl.sew);
    end else begin
      case (prod_ctrl.op)
        vlane_pkg::OP_MULH: result_d = hi_slice;
        vlane_pkg::OP_WMUL: result_d = wide_slice;
        default:            result_d = cut_sew(lo_slice, prod_ctrl.sew);
      endcase
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= prod_valid & ~flush;
    end
  end

  // result only moves when a product arrives
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      out_resp <= '0;
    end else if (prod_valid) begin
      out_resp.result <= result_d;
    end
  end

endmodule

`default_nettype wire

// File: vmul/vmultiply_unit.sv
/* lane multiply unit top: operand prep, multiplier and result stages */
`timescale 1ns/1ns
`default_nettype none
`include "vlane_defines.svh"

module vmultiply_unit (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 flush,
  input  logic                 in_valid,
  input  vlane_pkg::mul_req_t  in_req,
  output logic                 out_valid,
  output vlane_pkg::mul_resp_t out_resp
);

  // stage 1 to stage 2
  logic                       prep_valid;
  logic [`VLANE_FACTOR_W-1:0] factor_a;
  logic [`VLANE_FACTOR_W-1:0] factor_b;
  vlane_pkg::mul_ctrl_t       prep_ctrl;

  // stage 2 to stage 3
  logic                       prod_valid;
  logic [`VLANE_PROD_W-1:0]   product;
  vlane_pkg::mul_ctrl_t       prod_ctrl;

  vmul_operand_prep u_prep (
    .CLK(CLK), .nRST(nRST), .flush(flush),
    .in_valid(in_valid), .in_req(in_req),
    .prep_valid(prep_valid), .factor_a(factor_a), .factor_b(factor_b),
    .prep_ctrl(prep_ctrl)
  );

  vmul_multiplier u_mult (
    .CLK(CLK), .nRST(nRST), .flush(flush),
    .prep_valid(prep_valid), .factor_a(factor_a), .factor_b(factor_b),
    .prep_ctrl(prep_ctrl),
    .prod_valid(prod_valid), .product(product), .prod_ctrl(prod_ctrl)
  );

  vmul_result_unit u_result (
    .CLK(CLK), .nRST(nRST), .flush(flush),
    .prod_valid(prod_valid), .product(product), .prod_ctrl(prod_ctrl),
    .out_valid(out_valid), .out_resp(out_resp)
  );

endmodule

`default_nettype wire

// File: testbench/vmul_chk.sv
/* bound assertions on the lane multiply strobes: reset, latency, flush */
`timescale 1ns/1ns
`default_nettype none

module vmul_chk (
  input logic CLK,
  input logic nRST,
  input logic flush,
  input logic in_valid,
  input logic out_valid
);

  // no strobe while reset is held
  assert property (@(posedge CLK) !nRST |-> !out_valid)
    else $error("out_valid high during reset");

  // request with three clean edges gives its response
  assert property (@(posedge CLK) disable iff (!nRST)
    ($past(in_valid, 3) && !$past(flush, 3) && !$past(flush, 2) && !$past(flush, 1))
      |-> out_valid)
    else $error("out_valid missing three cycles after in_valid");

  // pipeline is empty for two cycles after a flush
  assert property (@(posedge CLK) disable iff (!nRST)
    ($past(flush, 1) || $past(flush, 2)) |-> !out_valid)
    else $error("out_valid high right after flush");

endmodule

bind vmultiply_unit vmul_chk u_chk (
  .CLK(CLK),
  .nRST(nRST),
  .flush(flush),
  .in_valid(in_valid),
  .out_valid(out_valid)
);

`default_nettype wire

// File: testbench/vmul_tb.sv
/* lane multiply testbench with hand and LFSR stimulus table, reference model,
   in-order response and latency checks, flush cases and timeout */
`timescale 1ns/1ns
`default_nettype none
`include "vlane_defines.svh"

module vmul_tb;

  localparam int MAX_ROWS     = 80;
  localparam int RESET_CYCLES = 8;
  localparam int MARGIN       = 20;

  // request, flush flag and expected result for one cycle
  typedef struct packed {
    logic                   valid;
    logic                   flush;
    vlane_pkg::mul_req_t    req;
    logic [`VLANE_XLEN-1:0] exp_val;
  } row_t;

  // expected result and the edge its request was sampled on
  typedef struct packed {
    logic [`VLANE_XLEN-1:0] result;
    logic [31:0]            issue;
  } exp_t;

  logic                 CLK;
  logic                 nRST;
  logic                 flush;
  logic                 in_valid;
  vlane_pkg::mul_req_t  in_req;
  logic                 out_valid;
  vlane_pkg::mul_resp_t out_resp;

  row_t        rows [MAX_ROWS];
  int          n_fill;
  exp_t        exp_q [$];
  exp_t        head;
  logic [15:0] lfsr_state;
  int          edge_cnt;
  int          cycle_limit;
  int          errors;
  int          checks;
  int          i;

  vmultiply_unit DUT (
    .CLK(CLK), .nRST(nRST), .flush(flush),
    .in_valid(in_valid), .in_req(in_req),
    .out_valid(out_valid), .out_resp(out_resp)
  );

  always #20 CLK = ~CLK;

  // taps x^16 + x^14 + x^13 + x^11 + 1 and one step per bit
  function automatic logic [31:0] lfsr_bits(input int count);
    logic [31:0] r;
    logic        fb;
    int          k;
    r = '0;
    for (k = 0; k < count; k++) begin
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  // low n bits sign or zero filled to 64
  function automatic logic [63:0] widen(input logic [31:0] v, input int n, input logic sgn);
    logic [63:0] m;
    logic [63:0] x;
    m = (64'd1 << n) - 64'd1;
    x = {32'd0, v} & m;
    if (sgn && x[n-1]) begin
      x = x | ~m;
    end
    return x;
  endfunction

  // expected result with the product kept mod 2^64
  function automatic logic [31:0] ref_result(input vlane_pkg::mul_req_t r);
    int          n;
    logic        swap;
    logic [31:0] mcand;
    logic [31:0] addend;
    logic [63:0] mask;
    logic [63:0] p;
    logic [63:0] res;
    n = (r.sew == vlane_pkg::SEW8) ? 8 : (r.sew == vlane_pkg::SEW16) ? 16 : 32;
    mask = (64'd1 << n) - 64'd1;
    // madd and nmsub multiply by vd and add vs2
    swap = (r.op == vlane_pkg::OP_MADD) || (r.op == vlane_pkg::OP_NMSUB);
    mcand = swap ? r.vd : r.vs2;
    addend = swap ? r.vs2 : r.vd;
    p = widen(r.vs1, n, r.signed_ops[0]) * widen(mcand, n, r.signed_ops[1]);
    case (r.op)
      vlane_pkg::OP_MULH: res = (p >> n) & mask;
      vlane_pkg::OP_WMUL: res = p & ((n == 32) ? mask : ((64'd1 << (2 * n)) - 64'd1));
      vlane_pkg::OP_MACC, vlane_pkg::OP_MADD: res = ({32'd0, addend} + p) & mask;
      vlane_pkg::OP_NMSAC, vlane_pkg::OP_NMSUB: res = ({32'd0, addend} - p) & mask;
      default: res = p & mask;
    endcase
    return res[31:0];
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("ERROR %s got %h expected %h at edge %0d", name, got, want, edge_cnt);
    end
  endtask

  task automatic add_row(input logic valid, input logic flush_row,
                         input vlane_pkg::mul_req_t req, input logic [31:0] exp_val);
    rows[n_fill].valid   = valid;
    rows[n_fill].flush   = flush_row;
    rows[n_fill].req     = req;
    rows[n_fill].exp_val = exp_val;
    n_fill++;
  endtask

  task automatic add_hand(input vlane_pkg::mul_op_t op, input vlane_pkg::sew_t sew,
                          input logic [1:0] sgn, input logic [31:0] vs1,
                          input logic [31:0] vs2, input logic [31:0] vd,
                          input logic [31:0] exp_val);
    vlane_pkg::mul_req_t req;
    req.vs1 = vs1;
    req.vs2 = vs2;
    req.vd = vd;
    req.sew = sew;
    req.op = op;
    req.signed_ops = sgn;
    add_row(1'b1, 1'b0, req, exp_val);
  endtask

  // LFSR operands and signedness with the expected value from the model
  task automatic add_rand(input vlane_pkg::mul_op_t op, input vlane_pkg::sew_t sew);
    vlane_pkg::mul_req_t req;
    logic [31:0]         sgn;
    req.vs1 = lfsr_bits(32);
    req.vs2 = lfsr_bits(32);
    req.vd = lfsr_bits(32);
    sgn = lfsr_bits(2);
    req.signed_ops = sgn[1:0];
    req.sew = sew;
    req.op = op;
    add_row(1'b1, 1'b0, req, ref_result(req));
  endtask

  task automatic build_rows();
    int k;
    n_fill = 0;
    // idle after reset
    repeat (3) add_row(1'b0, 1'b0, '0, '0);
    // low and high slices over every signedness and the most negative values
    add_hand(vlane_pkg::OP_MUL, vlane_pkg::SEW8, 2'b11, 'habcdef80, 'h12345680, 'h0, 'h00);
    add_hand(vlane_pkg::OP_MULH, vlane_pkg::SEW8, 2'b11, 'habcdef80, 'h12345680, 'h0, 'h40);
    add_hand(vlane_pkg::OP_MULH, vlane_pkg::SEW8, 2'b00, 'hff, 'hffffffff, 'h0, 'hfe);
    add_hand(vlane_pkg::OP_MULH, vlane_pkg::SEW8, 2'b01, 'hff, 'hff, 'h0, 'hff);
    add_hand(vlane_pkg::OP_MULH, vlane_pkg::SEW8, 2'b10, 'h80, 'h80, 'h0, 'hc0);
    add_hand(vlane_pkg::OP_MUL, vlane_pkg::SEW16, 2'b11, 'h8000, 'h7fff, 'h0, 'h8000);
    add_hand(vlane_pkg::OP_MULH, vlane_pkg::SEW16, 2'b11, 'h8000, 'h7fff, 'h0, 'hc000);
    add_hand(vlane_pkg::OP_MULH, vlane_pkg::SEW16, 2'b00, 'h1234ffff, 'hffff, 'h0, 'hfffe);
    add_hand(vlane_pkg::OP_MULH, vlane_pkg::SEW16, 2'b01, 'h8000, 'hffff, 'h0, 'h8000);
    add_hand(vlane_pkg::OP_MULH, vlane_pkg::SEW16, 2'b10, 'hffff, 'h8000, 'h0, 'h8000);
    add_hand(vlane_pkg::OP_MUL, vlane_pkg::SEW32, 2'b11, 'h80000000, 'h80000000, 'h0, 'h0);
    add_hand(vlane_pkg::OP_MULH, vlane_pkg::SEW32, 2'b11, 'h80000000, 'h80000000, 'h0,
             'h40000000);
    add_hand(vlane_pkg::OP_MULH, vlane_pkg::SEW32, 2'b00, 'hffffffff, 'hffffffff, 'h0,
             'hfffffffe);
    add_hand(vlane_pkg::OP_MULH, vlane_pkg::SEW32, 2'b01, 'hffffffff, 'hffffffff, 'h0,
             'hffffffff);
    add_hand(vlane_pkg::OP_MULH, vlane_pkg::SEW32, 2'b10, 'h80000000, 'hffffffff, 'h0,
             'hffffffff);
    add_hand(vlane_pkg::OP_MUL, vlane_pkg::SEW32, 2'b00, 'hffffffff, 'hffffffff, 'h0, 'h1);
    // widening with upper input bits ignored
    add_hand(vlane_pkg::OP_WMUL, vlane_pkg::SEW8, 2'b11, 'hffffff80, 'h7f, 'h0, 'hc080);
    add_hand(vlane_pkg::OP_WMUL, vlane_pkg::SEW16, 2'b00, 'hdeadffff, 'hbeefffff, 'h0,
             'hfffe0001);
    add_hand(vlane_pkg::OP_WMUL, vlane_pkg::SEW32, 2'b11, 'h80000000, 'h3, 'h0, 'h80000000);
    // wrapping fused forms where madd and nmsub catch swapped vd and vs2
    add_hand(vlane_pkg::OP_MACC, vlane_pkg::SEW8, 2'b00, 'h10, 'h1, 'h555555f0, 'h00);
    add_hand(vlane_pkg::OP_NMSAC, vlane_pkg::SEW8, 2'b11, 'h3, 'h2, 'h5, 'hff);
    add_hand(vlane_pkg::OP_MADD, vlane_pkg::SEW16, 2'b00, 'h2, 'h7fff, 'h8001, 'h8001);
    add_hand(vlane_pkg::OP_NMSUB, vlane_pkg::SEW16, 2'b11, 'h2, 'h1, 'h9, 'hffef);
    add_hand(vlane_pkg::OP_MACC, vlane_pkg::SEW32, 2'b11, 'h10000, 'h10000, 'hffffffff,
             'hffffffff);
    add_hand(vlane_pkg::OP_NMSAC, vlane_pkg::SEW32, 2'b00, 'h1, 'h1, 'h0, 'hffffffff);
    add_hand(vlane_pkg::OP_MADD, vlane_pkg::SEW32, 2'b00, 'h3, 'h1, 'h55555556, 'h3);
    add_hand(vlane_pkg::OP_NMSUB, vlane_pkg::SEW8, 2'b00, 'h3, 'h7, 'h5, 'hf8);
    // every op at every sew back to back
    for (k = 0; k < 28; k++) begin
      add_rand(vlane_pkg::mul_op_t'(k % 7), vlane_pkg::sew_t'(k % 3));
    end
    // last one survives and the next two are flushed in flight
    add_rand(vlane_pkg::OP_MUL, vlane_pkg::SEW16);
    add_rand(vlane_pkg::OP_MACC, vlane_pkg::SEW8);
    add_rand(vlane_pkg::OP_MULH, vlane_pkg::SEW32);
    add_row(1'b0, 1'b1, '0, '0);
    // straight after the flush
    add_rand(vlane_pkg::OP_WMUL, vlane_pkg::SEW16);
    add_rand(vlane_pkg::OP_NMSUB, vlane_pkg::SEW32);
    repeat (2) add_row(1'b0, 1'b0, '0, '0);
    // request on the flush edge is dropped too
    add_rand(vlane_pkg::OP_MADD, vlane_pkg::SEW16);
    rows[n_fill-1].flush = 1'b1;
    add_rand(vlane_pkg::OP_MADD, vlane_pkg::SEW8);
  endtask

  // flush at edge f drops requests sampled on f-2 to f
  task automatic drop_in_flight(input int flush_edge);
    while (exp_q.size() > 0 && int'(exp_q[exp_q.size()-1].issue) >= flush_edge - 2) begin
      void'(exp_q.pop_back());
    end
  endtask

  task automatic apply_row(input row_t r);
    int   next_edge;
    exp_t e;
    next_edge = edge_cnt + 1;
    in_valid = r.valid;
    flush = r.flush;
    in_req = r.req;
    if (r.flush) begin
      drop_in_flight(next_edge);
    end else if (r.valid) begin
      e.result = r.exp_val;
      e.issue = next_edge;
      exp_q.push_back(e);
    end
  endtask

  task automatic print_counts();
    $display("checks %0d  errors %0d", checks, errors);
  endtask

  // responses in order and each checked for value and latency
  always @(posedge CLK) begin
    edge_cnt = edge_cnt + 1;
    if (out_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("response on edge %0d with no request outstanding", edge_cnt);
      end else begin
        head = exp_q.pop_front();
        check_value("out_resp.result", out_resp.result, head.result);
        check_value("out_valid latency", edge_cnt - head.issue, `VLANE_MUL_LAT);
      end
    end
    if (edge_cnt >= cycle_limit) begin
      errors++;
      $display("timeout at edge %0d with %0d responses never seen", edge_cnt, exp_q.size());
      print_counts();
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial begin
    CLK = 1'b0;
    nRST = 1'b0;
    flush = 1'b0;
    in_valid = 1'b0;
    in_req = '0;
    lfsr_state = 16'd26683;
    edge_cnt = 0;
    errors = 0;
    checks = 0;
    build_rows();
    // rows plus reset, latency and drain
    cycle_limit = RESET_CYCLES + n_fill + `VLANE_MUL_LAT + MARGIN;
    repeat (RESET_CYCLES) @(posedge CLK);
    #2;
    nRST = 1'b1;
    for (i = 0; i < n_fill; i++) begin
      @(posedge CLK);
      #2;
      apply_row(rows[i]);
    end
    @(posedge CLK);
    #2;
    in_valid = 1'b0;
    flush = 1'b0;
    in_req = '0;
    while (exp_q.size() != 0) begin
      @(posedge CLK);
    end
    // catch any stray strobe
    repeat (`VLANE_MUL_LAT + 2) @(posedge CLK);
    print_counts();
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+common
common/vlane_pkg.sv
vmul/vmul_operand_prep.sv
vmul/vmul_multiplier.sv
vmul/vmul_result_unit.sv
vmul/vmultiply_unit.sv
testbench/vmul_chk.sv
testbench/vmul_tb.sv

// File: Makefile
# Verilator build and run for the lane multiply unit testbench

TOP := vmul_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f

# pass only if the testbench printed its pass line
run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "NO ERRORS" $(LOG)

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f src.f

clean:
	rm -rf obj_dir $(LOG)
